// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the EX1 lane simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f src.f --top-module ExLaneTb \
	--Mdir obj_dir -o ExLaneSim

./obj_dir/ExLaneSim +verilator+error+limit+1000

// ==== source/ExConvert.sv ====
// Sign and zero extension of byte, word and dword, feeding the CONV_RR result of EX1
`timescale 1ns/1ps
`include "ExLane_settings.svh"

module ExConvert (
	input  logic [`EX_VAL_W-1:0] value,
	input  logic [3:0]           subOp,
	output logic [`EX_VAL_W-1:0] convValue
);

	always_comb begin
		case (subOp)
			4'd0: begin
				convValue = {{(`EX_VAL_W-8){value[7]}}, value[7:0]};	// Byte, signed
			end
			4'd1: begin
				convValue = {{(`EX_VAL_W-8){1'b0}}, value[7:0]};	// Byte, unsigned
			end
			4'd2: begin
				convValue = {{(`EX_VAL_W-16){value[15]}}, value[15:0]};	// Word, signed
			end
			4'd3: begin
				convValue = {{(`EX_VAL_W-16){1'b0}}, value[15:0]};
			end
			4'd4: begin
				convValue = {{(`EX_VAL_W-32){value[31]}}, value[31:0]};	// Dword, signed
			end
			4'd5: begin
				convValue = {{(`EX_VAL_W-32){1'b0}}, value[31:0]};
			end
			default: begin
				convValue = value;	// Pass through
			end
		endcase
	end

endmodule

// ==== source/ExLaneEx1.sv ====
// EX1 stage of the secondary lane: condition gating, decode, direct results and trap hold
`timescale 1ns/1ps
`include "ExLane_settings.svh"

module ExLaneEx1
	import ExLanePkg::*;
(
	input  logic [7:0]           exUCmd,
	input  uIxt_u                exUIxt,
	input  logic [`EX_ID_W-1:0]  exIdRm,
	input  logic [`EX_VAL_W-1:0] exValRs,
	input  logic [`EX_VAL_W-1:0] exValRt,
	input  logic [`EX_VAL_W-1:0] exValRm,
	input  logic [`EX_IMM_W-1:0] exImm,
	input  logic                 exSrT,
	input  logic                 opBraFlush,

	input  logic [`EX_VAL_W-1:0] convValue,
	input  logic [31:0]          shift32Value,
	input  logic [`EX_VAL_W-1:0] shift64Value,

	output logic                 shiftArith,
	output logic [`EX_ID_W-1:0]  regIdRn1,
	output logic [`EX_VAL_W-1:0] regValRn1,
	output logic [`EX_ID_W-1:0]  heldIdRn1,
	output logic                 exHold
);

	cond_e cond;
	uCmd_e rawCmd;
	uCmd_e cmd;
	logic  opEnable;

	assign cond   = cond_e'(exUCmd[7:6]);
	assign rawCmd = uCmd_e'(exUCmd[5:0]);

	always_comb begin
		case (cond)
			AL:      opEnable = 1'b1;
			NV:      opEnable = 1'b0;
			CT:      opEnable = exSrT;
			default: opEnable = !exSrT;	// CF
		endcase
		if (opBraFlush)
			opEnable = 1'b0;	// Flushed ops behave as NOP
	end

	assign cmd = opEnable ? rawCmd : NOP;

	// Shift type comes from the op itself, the result is only used when enabled
	assign shiftArith = (rawCmd == SHAD3) || (rawCmd == SHADQ3);

	always_comb begin
		regIdRn1  = `EX_GR_ZZR;
		regValRn1 = '0;
		heldIdRn1 = `EX_GR_ZZR;
		exHold    = 1'b0;

		case (cmd)
			NOP, LEA_MR, MOV_MR, FMOV_RM, FMOV_MR, POPX, ALUCMP, MUL3: begin
			end
			MOV_RM: regValRn1 = exValRs;	// Store data, no register write
			PUSHX:  regValRn1 = exValRm;

			ALU3, UNARY, MULW3, FPU3: begin
				heldIdRn1 = exIdRm;	// Result arrives from another unit
			end

			CONV_RR: begin
				regIdRn1  = exIdRm;
				regValRn1 = convValue;
			end

			MOV_IR: begin
				regIdRn1 = exIdRm;
				case (exUIxt.sub.subOp)
					4'd0: regValRn1 = {{32{exImm[32]}}, exImm[31:0]};	// LDI
					4'd1: regValRn1 = {exValRs[55:0], exImm[7:0]};	// LDISH8
					4'd2: regValRn1 = {exValRs[47:0], exImm[15:0]};
					4'd3: regValRn1 = {exValRs[31:0], exImm[31:0]};
					default: regValRn1 = exValRt;
				endcase
			end

			SHAD3: begin
				regIdRn1  = exIdRm;
				regValRn1 = {{32{shift32Value[31]}}, shift32Value};
			end
			SHLD3: begin
				regIdRn1  = exIdRm;
				regValRn1 = {32'd0, shift32Value};
			end
			SHADQ3, SHLDQ3: begin
				regIdRn1  = exIdRm;
				regValRn1 = shift64Value;
			end

			OP_IXS: begin
				case (ixsIdx_e'(exUIxt.ix.index))
					IXS_NOP: begin
					end
					IXS_MOVT: begin
						regIdRn1  = exIdRm;
						regValRn1 = {{(`EX_VAL_W-1){1'b0}}, exSrT};
					end
					IXS_MOVNT: begin
						regIdRn1  = exIdRm;
						regValRn1 = {{(`EX_VAL_W-1){1'b0}}, !exSrT};
					end
					default: exHold = 1'b1;	// Unhandled IXS index
				endcase
			end

			OP_IXT: begin
				case (ixtIdx_e'(exUIxt.ix.index))
					IXT_NOP, IXT_SLEEP: begin
					end
					default: exHold = 1'b1;	// BREAK or unhandled IXT index
				endcase
			end

			default: exHold = 1'b1;	// INVOP and unknown codes
		endcase
	end

endmodule

// ==== source/ExLaneIdLatch.sv ====
// ID-to-EX1 pipeline register, captures the decoded micro-op and operands and holds on stall
`timescale 1ns/1ps
`include "ExLane_settings.svh"

module ExLaneIdLatch
	import ExLanePkg::*;
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 hold,

	input  logic [7:0]           opUCmd,
	input  logic [7:0]           opUIxt,
	input  logic [`EX_ID_W-1:0]  regIdRm,
	input  logic [`EX_VAL_W-1:0] regValRs,
	input  logic [`EX_VAL_W-1:0] regValRt,
	input  logic [`EX_VAL_W-1:0] regValRm,
	input  logic [`EX_IMM_W-1:0] regValImm,
	input  logic                 srT,

	output logic [7:0]           exUCmd,
	output uIxt_u                exUIxt,
	output logic [`EX_ID_W-1:0]  exIdRm,
	output logic [`EX_VAL_W-1:0] exValRs,
	output logic [`EX_VAL_W-1:0] exValRt,
	output logic [`EX_VAL_W-1:0] exValRm,
	output logic [`EX_IMM_W-1:0] exImm,
	output logic                 exSrT
);

	always_ff @(posedge clock) begin
		if (rst) begin
			exUCmd  <= {AL, NOP};	// Unconditional NOP
			exUIxt  <= '0;
			exIdRm  <= `EX_GR_ZZR;
			exValRs <= '0;
			exValRt <= '0;
			exValRm <= '0;
			exImm   <= '0;
			exSrT   <= 1'b0;
		end else if (!hold) begin
			exUCmd  <= opUCmd;
			exUIxt  <= opUIxt;
			exIdRm  <= regIdRm;
			exValRs <= regValRs;
			exValRt <= regValRt;
			exValRm <= regValRm;
			exImm   <= regValImm;
			exSrT   <= srT;
		end
		// Stalled stage keeps the trapping op in place
	end

endmodule

// ==== source/ExLanePkg.sv ====
// Shared micro-op, condition and index types for the EX1 lane, imported by its modules
package ExLanePkg;

	// Micro-op field of opUCmd, bits 5:0
	typedef enum logic [5:0] {
		NOP     = 6'd0,
		INVOP   = 6'd1,
		LEA_MR  = 6'd2,
		MOV_RM  = 6'd3,
		MOV_MR  = 6'd4,
		FMOV_RM = 6'd5,
		FMOV_MR = 6'd6,
		PUSHX   = 6'd7,
		POPX    = 6'd8,
		ALU3    = 6'd9,
		UNARY   = 6'd10,
		ALUCMP  = 6'd11,
		CONV_RR = 6'd12,
		MOV_IR  = 6'd13,
		MULW3   = 6'd14,
		SHAD3   = 6'd15,
		SHLD3   = 6'd16,
		SHADQ3  = 6'd17,
		SHLDQ3  = 6'd18,
		MUL3    = 6'd19,
		FPU3    = 6'd20,
		OP_IXS  = 6'd21,
		OP_IXT  = 6'd22
	} uCmd_e;

	// Condition field of opUCmd, bits 7:6
	typedef enum logic [1:0] {
		AL = 2'd0,	// Always
		NV = 2'd1,	// Never
		CT = 2'd2,	// If SR.T
		CF = 2'd3	// If not SR.T
	} cond_e;

	typedef enum logic [5:0] {
		IXS_NOP   = 6'd0,
		IXS_MOVT  = 6'd1,
		IXS_MOVNT = 6'd2
	} ixsIdx_e;

	typedef enum logic [5:0] {
		IXT_NOP   = 6'd0,
		IXT_SLEEP = 6'd1,
		IXT_BREAK = 6'd2
	} ixtIdx_e;

	// opUIxt is read as a 6-bit index or as a 4-bit sub-operation, depending on the micro-op
	typedef union packed {
		struct packed {
			logic [1:0] resv;
			logic [5:0] index;	// OP_IXS / OP_IXT
		} ix;
		struct packed {
			logic [3:0] resv;
			logic [3:0] subOp;	// MOV_IR / CONV_RR
		} sub;
	} uIxt_u;

endpackage

// ==== source/ExLaneTop.sv ====
// Top level of the EX1 lane, wiring the ID latch, the stage, both shifters and the converter
`timescale 1ns/1ps
`include "ExLane_settings.svh"

module ExLaneTop
	import ExLanePkg::*;
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic [7:0]           opUCmd,
	input  logic [7:0]           opUIxt,
	input  logic [`EX_ID_W-1:0]  regIdRm,
	input  logic [`EX_VAL_W-1:0] regValRs,
	input  logic [`EX_VAL_W-1:0] regValRt,
	input  logic [`EX_VAL_W-1:0] regValRm,
	input  logic [`EX_IMM_W-1:0] regValImm,
	input  logic                 srT,
	input  logic                 opBraFlush,

	output logic [`EX_ID_W-1:0]  regIdRn1,
	output logic [`EX_VAL_W-1:0] regValRn1,
	output logic [`EX_ID_W-1:0]  heldIdRn1,
	output logic                 exHold
);

	logic [7:0]           exUCmd;
	uIxt_u                exUIxt;
	logic [`EX_ID_W-1:0]  exIdRm;
	logic [`EX_VAL_W-1:0] exValRs;
	logic [`EX_VAL_W-1:0] exValRt;
	logic [`EX_VAL_W-1:0] exValRm;
	logic [`EX_IMM_W-1:0] exImm;
	logic                 exSrT;
	logic                 shiftArith;
	logic [31:0]          shift32Value;
	logic [`EX_VAL_W-1:0] shift64Value;
	logic [`EX_VAL_W-1:0] convValue;

	ExLaneIdLatch latch0 (
		.clock(clock), .rst(rst), .hold(exHold),	// Stage stall freezes the latch
		.opUCmd(opUCmd), .opUIxt(opUIxt), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValRt(regValRt), .regValRm(regValRm),
		.regValImm(regValImm), .srT(srT),
		.exUCmd(exUCmd), .exUIxt(exUIxt), .exIdRm(exIdRm),
		.exValRs(exValRs), .exValRt(exValRt), .exValRm(exValRm),
		.exImm(exImm), .exSrT(exSrT)
	);

	ExShifter #(.WIDTH(32)) shift32 (
		.value(exValRs[31:0]), .amount(exValRt[7:0]), .arith(shiftArith),
		.shiftValue(shift32Value)
	);

	ExShifter #(.WIDTH(`EX_VAL_W)) shift64 (
		.value(exValRs), .amount(exValRt[7:0]), .arith(shiftArith),
		.shiftValue(shift64Value)
	);

	ExConvert conv0 (
		.value(exValRs), .subOp(exUIxt.sub.subOp), .convValue(convValue)
	);

	ExLaneEx1 ex1 (
		.exUCmd(exUCmd), .exUIxt(exUIxt), .exIdRm(exIdRm),
		.exValRs(exValRs), .exValRt(exValRt), .exValRm(exValRm),
		.exImm(exImm), .exSrT(exSrT), .opBraFlush(opBraFlush),
		.convValue(convValue), .shift32Value(shift32Value),
		.shift64Value(shift64Value), .shiftArith(shiftArith),
		.regIdRn1(regIdRn1), .regValRn1(regValRn1),
		.heldIdRn1(heldIdRn1), .exHold(exHold)
	);

endmodule

// ==== source/ExLane_settings.svh ====
// Lane width and register-ID macros, included by the EX1 lane RTL and its property module
`ifndef EX_LANE_SETTINGS_SVH
`define EX_LANE_SETTINGS_SVH

// Register value width
`define EX_VAL_W 64

// Register ID width
`define EX_ID_W 6

// Immediate width, bit 32 carries the sign-extension flag
`define EX_IMM_W 33

// Null register, used when nothing is written
`define EX_GR_ZZR 6'h3F

`endif

// ==== source/ExShifter.sv ====
// Combinational shifter by a signed 8-bit count, instantiated once per shift width in the lane
`timescale 1ns/1ps

module ExShifter #(
	parameter int WIDTH = 64
) (
	input  logic [WIDTH-1:0] value,
	input  logic [7:0]       amount,
	input  logic             arith,
	output logic [WIDTH-1:0] shiftValue
);

	logic [7:0]       mag;
	logic             fill;
	logic [WIDTH:0]   extValue;
	logic [WIDTH:0]   rightValue;

	// Magnitude of the count, -128 comes out as 128
	assign mag = amount[7] ? (8'd0 - amount) : amount;

	assign fill = arith & value[WIDTH-1];	// Sign fill only when arithmetic

	// One extra bit on top carries the fill into the arithmetic shift
	assign extValue   = {fill, value};
	assign rightValue = $signed(extValue) >>> mag;

	always_comb begin
		if (!amount[7]) begin
			if (mag >= WIDTH)
				shiftValue = '0;	// Left saturates to zero
			else
				shiftValue = value << mag;
		end else begin
			if (mag >= WIDTH)
				shiftValue = {WIDTH{fill}};	// All sign bits or zero
			else
				shiftValue = rightValue[WIDTH-1:0];
		end
	end

endmodule

// ==== src.f ====
+incdir+source
source/ExLanePkg.sv
source/ExShifter.sv
source/ExConvert.sv
source/ExLaneIdLatch.sv
source/ExLaneEx1.sv
source/ExLaneTop.sv
tb/ExLane_properties.sv
tb/ExLaneTb.sv

// ==== tb/ExLaneTb.sv ====
// Testbench for the EX1 lane, drives dut0 with directed and random micro-ops for the bound checker
`timescale 1ns/1ps
`include "ExLane_settings.svh"

module ExLaneTb;
	import ExLanePkg::*;

	logic                 clock = 1'b0;
	logic                 rst;
	logic [7:0]           opUCmd;
	logic [7:0]           opUIxt;
	logic [`EX_ID_W-1:0]  regIdRm;
	logic [`EX_VAL_W-1:0] regValRs;
	logic [`EX_VAL_W-1:0] regValRt;
	logic [`EX_VAL_W-1:0] regValRm;
	logic [`EX_IMM_W-1:0] regValImm;
	logic                 srT;
	logic                 opBraFlush;
	logic [`EX_ID_W-1:0]  regIdRn1;
	logic [`EX_VAL_W-1:0] regValRn1;
	logic [`EX_ID_W-1:0]  heldIdRn1;
	logic                 exHold;
	string                testName = "reset";
	int unsigned          seedVal;
	logic [5:0]           quietOps [7] = '{LEA_MR, MOV_MR, FMOV_RM, FMOV_MR, POPX, ALUCMP, MUL3};

	ExLaneTop dut0 (
		.clock(clock), .rst(rst), .opUCmd(opUCmd), .opUIxt(opUIxt), .regIdRm(regIdRm),
		.regValRs(regValRs), .regValRt(regValRt), .regValRm(regValRm),
		.regValImm(regValImm), .srT(srT), .opBraFlush(opBraFlush),
		.regIdRn1(regIdRn1), .regValRn1(regValRn1), .heldIdRn1(heldIdRn1), .exHold(exHold)
	);

	always #20 clock = ~clock;	// 40 ns period

	task automatic reportFailure(input string why);
		$display("CHECKS FAILED");
		$fatal(1, "%s in test %s", why, testName);
	endtask

	task automatic nextCycle();
		@(posedge clock);
		#2;	// Drive point after the edge
	endtask

	task automatic randomOperands();
		regIdRm   = 6'($urandom_range(0, 62));
		regValRs  = {$urandom, $urandom};
		regValRt  = {$urandom, $urandom};
		regValRm  = {$urandom, $urandom};
		regValImm = {1'($urandom), $urandom};
		srT       = 1'($urandom);
	endtask

	task automatic issueOp(input logic [1:0] cond, input logic [5:0] op, input logic [7:0] ixt);
		opUCmd = {cond, op};
		opUIxt = ixt;
		nextCycle();
	endtask

	task automatic waitHold(input logic level);
		int n;
		n = 0;
		while (exHold !== level) begin
			if (n >= 20)
				reportFailure($sformatf("exHold did not reach %0b within 20 cycles", level));
			nextCycle();
			n++;
		end
	endtask

	// Trap, stall under changing inputs, then release by flush
	task automatic trapAndRelease(input logic [5:0] op, input logic [7:0] ixt);
		randomOperands();
		issueOp(AL, op, ixt);
		waitHold(1'b1);
		repeat (3) begin
			randomOperands();
			issueOp(AL, MOV_RM, 8'd0);	// Ignored while stalled
		end
		randomOperands();
		opBraFlush = 1'b1;
		opUCmd = {AL, MOV_IR};
		opUIxt = 8'd0;
		waitHold(1'b0);
		nextCycle();
		opBraFlush = 1'b0;
		randomOperands();
		issueOp(AL, MOV_RM, 8'd0);
	endtask

	always @(posedge clock)
		if (dut0.props0.failCount != 0)
			reportFailure("a bound assertion failed");

	initial begin
		seedVal    = $urandom(29667);
		rst        = 1'b1;
		opUCmd     = 8'h00;
		opUIxt     = 8'h00;
		regIdRm    = `EX_GR_ZZR;
		regValRs   = '0;
		regValRt   = '0;
		regValRm   = '0;
		regValImm  = '0;
		srT        = 1'b0;
		opBraFlush = 1'b0;
		repeat (2) @(posedge clock);
		#2;
		rst = 1'b0;
		nextCycle();
		nextCycle();

		testName = "direct";
		repeat (4) begin
			for (int s = 0; s < 8; s++) begin
				randomOperands();
				issueOp(AL, MOV_IR, 8'($urandom & 32'hF0) | 8'(s));	// Upper bits are reserved
				randomOperands();
				issueOp(AL, CONV_RR, 8'(s));
			end
			randomOperands();
			issueOp(AL, MOV_RM, 8'($urandom));
			randomOperands();
			issueOp(AL, PUSHX, 8'($urandom));
			randomOperands();
			issueOp(AL, ALU3, 8'($urandom));
			randomOperands();
			issueOp(AL, UNARY, 8'($urandom));
			randomOperands();
			issueOp(AL, MULW3, 8'($urandom));
			randomOperands();
			issueOp(AL, FPU3, 8'($urandom));
			foreach (quietOps[i]) begin
				randomOperands();
				issueOp(AL, quietOps[i], 8'($urandom));	// No visible result
			end
			randomOperands();
			issueOp(AL, OP_IXS, 8'(IXS_NOP));
			randomOperands();
			issueOp(AL, OP_IXS, 8'(IXS_MOVT));
			randomOperands();
			issueOp(AL, OP_IXS, 8'(IXS_MOVNT));
			randomOperands();
			issueOp(AL, OP_IXT, 8'(IXT_NOP));
			randomOperands();
			issueOp(AL, OP_IXT, 8'(IXT_SLEEP));
		end

		testName = "shift";
		for (int a = -70; a <= 70; a++) begin
			randomOperands();
			regValRt[7:0] = 8'(a);
			issueOp(AL, SHAD3, 8'd0);
			randomOperands();
			regValRt[7:0] = 8'(a);
			issueOp(AL, SHLD3, 8'd0);
			randomOperands();
			regValRt[7:0] = 8'(a);
			issueOp(AL, SHADQ3, 8'd0);
			randomOperands();
			regValRt[7:0] = 8'(a);
			issueOp(AL, SHLDQ3, 8'd0);
		end
		repeat (40) begin
			randomOperands();
			issueOp(AL, 6'($urandom_range(15, 18)), 8'd0);	// Full 8-bit counts
		end

		testName = "condition";
		for (int c = 0; c < 4; c++) begin
			for (int t = 0; t < 2; t++) begin
				randomOperands();
				srT = 1'(t);
				issueOp(2'(c), MOV_IR, 8'd0);
				randomOperands();
				srT = 1'(t);
				issueOp(2'(c), OP_IXS, 8'(IXS_MOVT));
			end
		end
		randomOperands();
		issueOp(NV, INVOP, 8'd0);	// Never taken, so no trap

		testName = "flush";
		randomOperands();
		issueOp(AL, MOV_IR, 8'd0);
		opBraFlush = 1'b1;	// Drops the latched MOV_IR
		randomOperands();
		issueOp(AL, ALU3, 8'd0);
		randomOperands();
		issueOp(AL, MOV_RM, 8'd0);	// ALU3 is dropped too
		opBraFlush = 1'b0;
		randomOperands();
		issueOp(AL, PUSHX, 8'd0);

		testName = "trap";
		trapAndRelease(INVOP, 8'($urandom));
		trapAndRelease(OP_IXT, 8'(IXT_BREAK));
		trapAndRelease(OP_IXS, 8'd7);
		trapAndRelease(OP_IXT, 8'd12);
		trapAndRelease(6'd45, 8'd0);

		testName = "drain";
		nextCycle();
		nextCycle();
		if (dut0.props0.failCount != 0)
			reportFailure("a bound assertion failed");
		else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== tb/ExLane_properties.sv ====
// Bound checker for the EX1 lane, mirrors the ID latch and the EX1 rules and asserts the top outputs
`timescale 1ns/1ps
`include "ExLane_settings.svh"

module ExLaneProps
	import ExLanePkg::*;
(
	input logic                 clock,
	input logic                 rst,
	input logic [7:0]           opUCmd,
	input logic [7:0]           opUIxt,
	input logic [`EX_ID_W-1:0]  regIdRm,
	input logic [`EX_VAL_W-1:0] regValRs,
	input logic [`EX_VAL_W-1:0] regValRt,
	input logic [`EX_VAL_W-1:0] regValRm,
	input logic [`EX_IMM_W-1:0] regValImm,
	input logic                 srT,
	input logic                 opBraFlush,
	input logic [`EX_ID_W-1:0]  regIdRn1,
	input logic [`EX_VAL_W-1:0] regValRn1,
	input logic [`EX_ID_W-1:0]  heldIdRn1,
	input logic                 exHold
);

	int failCount = 0;	// Polled by the testbench

	logic [7:0]           mCmd;
	logic [7:0]           mIxt;
	logic [`EX_ID_W-1:0]  mIdRm;
	logic [`EX_VAL_W-1:0] mRs;
	logic [`EX_VAL_W-1:0] mRt;
	logic [`EX_VAL_W-1:0] mRm;
	logic [`EX_IMM_W-1:0] mImm;
	logic                 mSrT;
	logic                 en;
	logic [`EX_VAL_W-1:0] sh32;
	logic [`EX_VAL_W-1:0] sh64;
	logic [`EX_ID_W-1:0]  expId;
	logic [`EX_VAL_W-1:0] expVal;
	logic [`EX_ID_W-1:0]  expHeld;
	logic                 expHold;

	// Signed count rules, width is 32 or 64
	function automatic logic [63:0] shiftRef(input logic [63:0] v, input logic [7:0] amt,
			input logic arith, input int width);
		int n;
		logic sign;
		logic [63:0] mask;
		n = int'($signed(amt));
		mask = (width == 64) ? '1 : ((64'd1 << width) - 64'd1);
		sign = arith && ((v & (64'd1 << (width - 1))) != 64'd0);
		if (n >= width)
			return '0;
		else if (n >= 0)
			return (v << n) & mask;
		else if (-n >= width)
			return sign ? mask : '0;
		else
			return ((v & mask) >> -n) | (sign ? (mask & ~(mask >> -n)) : '0);
	endfunction

	// Reference copy of the ID latch, stalled by the expected hold
	always_ff @(posedge clock) begin
		if (rst) begin
			mCmd  <= 8'h00;	// AL NOP
			mIxt  <= '0;
			mIdRm <= `EX_GR_ZZR;
			mRs   <= '0;
			mRt   <= '0;
			mRm   <= '0;
			mImm  <= '0;
			mSrT  <= 1'b0;
		end else if (!expHold) begin
			mCmd  <= opUCmd;
			mIxt  <= opUIxt;
			mIdRm <= regIdRm;
			mRs   <= regValRs;
			mRt   <= regValRt;
			mRm   <= regValRm;
			mImm  <= regValImm;
			mSrT  <= srT;
		end
	end

	always_comb begin
		case (mCmd[7:6])
			2'd0: en = 1'b1;
			2'd1: en = 1'b0;
			2'd2: en = mSrT;
			default: en = !mSrT;
		endcase
		en = en && !opBraFlush;	// Flush wins over any condition
		sh32 = shiftRef({32'd0, mRs[31:0]}, mRt[7:0], mCmd[5:0] == SHAD3, 32);
		sh64 = shiftRef(mRs, mRt[7:0], mCmd[5:0] == SHADQ3, 64);
		expId   = `EX_GR_ZZR;
		expVal  = '0;
		expHeld = `EX_GR_ZZR;
		expHold = 1'b0;
		if (en) begin
			case (mCmd[5:0])
				NOP, LEA_MR, MOV_MR, FMOV_RM, FMOV_MR, POPX, ALUCMP, MUL3: begin
				end
				MOV_RM: expVal = mRs;
				PUSHX: expVal = mRm;
				ALU3, UNARY, MULW3, FPU3: expHeld = mIdRm;
				CONV_RR: begin
					expId = mIdRm;
					case (mIxt[3:0])
						4'd0: expVal = 64'($signed(mRs[7:0]));
						4'd1: expVal = {56'd0, mRs[7:0]};
						4'd2: expVal = 64'($signed(mRs[15:0]));
						4'd3: expVal = {48'd0, mRs[15:0]};
						4'd4: expVal = 64'($signed(mRs[31:0]));
						4'd5: expVal = {32'd0, mRs[31:0]};
						default: expVal = mRs;
					endcase
				end
				MOV_IR: begin
					expId = mIdRm;
					case (mIxt[3:0])
						4'd0: expVal = 64'($signed(mImm));	// Bit 32 is the sign
						4'd1: expVal = (mRs << 8) | {56'd0, mImm[7:0]};
						4'd2: expVal = (mRs << 16) | {48'd0, mImm[15:0]};
						4'd3: expVal = (mRs << 32) | {32'd0, mImm[31:0]};
						default: expVal = mRt;
					endcase
				end
				SHAD3: begin
					expId = mIdRm;
					expVal = 64'($signed(sh32[31:0]));
				end
				SHLD3: begin
					expId = mIdRm;
					expVal = sh32;
				end
				SHADQ3, SHLDQ3: begin
					expId = mIdRm;
					expVal = sh64;
				end
				OP_IXS: begin
					if (mIxt[5:0] == IXS_MOVT || mIxt[5:0] == IXS_MOVNT) begin
						expId = mIdRm;
						expVal = {63'd0, mSrT ^ (mIxt[5:0] == IXS_MOVNT)};
					end else if (mIxt[5:0] != IXS_NOP)
						expHold = 1'b1;
				end
				OP_IXT: expHold = (mIxt[5:0] != IXT_NOP) && (mIxt[5:0] != IXT_SLEEP);
				default: expHold = 1'b1;	// INVOP and unknown codes
			endcase
		end
	end

	idCheck: assert property (@(posedge clock) disable iff (rst) regIdRn1 == expId)
		else begin
			failCount++;
			$error("** Error regIdRn1: expected %h, actual %h", $sampled(expId), $sampled(regIdRn1));
		end

	valCheck: assert property (@(posedge clock) disable iff (rst) regValRn1 == expVal)
		else begin
			failCount++;
			$error("** Error regValRn1: expected %h, actual %h", $sampled(expVal),
				$sampled(regValRn1));
		end

	heldCheck: assert property (@(posedge clock) disable iff (rst) heldIdRn1 == expHeld)
		else begin
			failCount++;
			$error("** Error heldIdRn1: expected %h, actual %h", $sampled(expHeld),
				$sampled(heldIdRn1));
		end

	holdCheck: assert property (@(posedge clock) disable iff (rst) exHold == expHold)
		else begin
			failCount++;
			$error("** Error exHold: expected %b, actual %b", $sampled(expHold), $sampled(exHold));
		end

endmodule

bind ExLaneTop ExLaneProps props0 (
	.clock(clock), .rst(rst), .opUCmd(opUCmd), .opUIxt(opUIxt), .regIdRm(regIdRm),
	.regValRs(regValRs), .regValRt(regValRt), .regValRm(regValRm),
	.regValImm(regValImm), .srT(srT), .opBraFlush(opBraFlush),
	.regIdRn1(regIdRn1), .regValRn1(regValRn1), .heldIdRn1(heldIdRn1), .exHold(exHold)
);
